// ==== all.f ====
+incdir+verif
src/exec_pkg.sv
src/shift_right_arithmetic.sv
src/shift_left_logical.sv
src/adder_cla.sv
src/alu.sv
src/exec_pipeline.sv
src/alu_status_regs.sv
src/execute_stage.sv
verif/execute_stage_tb.sv

// ==== src/adder_cla.sv ====
`default_nettype none
`timescale 1ns/1ns

module adder_cla (
	input  wire exec_pkg::word_t a,
	input  wire exec_pkg::word_t b,
	input  wire                  carry_in,
	output exec_pkg::word_t      sum,
	output logic                 overflow
);
	import exec_pkg::*;

	word_t       gen;          // bit generate
	word_t       prop;         // bit propagate
	logic [3:0]  group_gen;
	logic [3:0]  group_prop;
	logic [4:0]  block_carry;  // carry into each 8-bit block, [4] is carry out
	logic [32:0] carry;

	assign gen  = a & b;
	assign prop = a ^ b;

	// first level, group signals per 8-bit block
	always_comb begin
		logic g_acc;
		logic p_acc;
		for (int blk = 0; blk < 4; blk++) begin
			g_acc = 1'b0;
			p_acc = 1'b1;
			for (int i = 0; i < 8; i++) begin
				g_acc = gen[8*blk+i] | (prop[8*blk+i] & g_acc);
				p_acc = p_acc & prop[8*blk+i];
			end
			group_gen[blk]  = g_acc;
			group_prop[blk] = p_acc;
		end
	end

	// second level lookahead across blocks
	assign block_carry[0] = carry_in;
	assign block_carry[1] = group_gen[0] | (group_prop[0] & carry_in);
	assign block_carry[2] = group_gen[1] | (group_prop[1] & group_gen[0])
		| (&group_prop[1:0] & carry_in);
	assign block_carry[3] = group_gen[2] | (group_prop[2] & group_gen[1])
		| (&group_prop[2:1] & group_gen[0])
		| (&group_prop[2:0] & carry_in);
	assign block_carry[4] = group_gen[3] | (group_prop[3] & group_gen[2])
		| (&group_prop[3:2] & group_gen[1])
		| (&group_prop[3:1] & group_gen[0])
		| (&group_prop[3:0] & carry_in);

	// bit carries inside each block start from its block carry
	always_comb begin
		for (int blk = 0; blk < 4; blk++) begin
			carry[8*blk] = block_carry[blk];
			for (int i = 0; i < 7; i++)
				carry[8*blk+i+1] = gen[8*blk+i] | (prop[8*blk+i] & carry[8*blk+i]);
		end
		carry[32] = block_carry[4];
	end

	assign sum      = prop ^ carry[31:0];
	assign overflow = carry[32] ^ carry[31];  // carry into vs out of sign bit

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none
`timescale 1ns/1ns

module alu (
	input  wire exec_pkg::word_t   data_a,
	input  wire exec_pkg::word_t   data_b,
	input  wire exec_pkg::alu_op_t alu_op,
	input  wire exec_pkg::shamt_t  shamt,
	output exec_pkg::word_t        result,
	output logic                   is_not_equal,
	output logic                   is_less_than,
	output logic                   overflow
);
	import exec_pkg::*;

	word_t sum_add;
	word_t sum_sub;
	word_t sll_out;
	word_t sra_out;
	logic  ovf_add;
	logic  ovf_sub;

	adder_cla u_add (
		.a        (data_a),
		.b        (data_b),
		.carry_in (1'b0),
		.sum      (sum_add),
		.overflow (ovf_add)
	);

	// a + ~b + 1, runs every cycle so the flags ignore the opcode
	adder_cla u_sub (
		.a        (data_a),
		.b        (~data_b),
		.carry_in (1'b1),
		.sum      (sum_sub),
		.overflow (ovf_sub)
	);

	shift_left_logical u_sll (
		.in    (data_a),
		.shamt (shamt),
		.out   (sll_out)
	);

	shift_right_arithmetic u_sra (
		.in    (data_a),
		.shamt (shamt),
		.out   (sra_out)
	);

	always_comb begin
		case (alu_op)
			op_add:  result = sum_add;
			op_sub:  result = sum_sub;
			op_and:  result = data_a & data_b;
			op_or:   result = data_a | data_b;
			op_sll:  result = sll_out;
			op_sra:  result = sra_out;
			default: result = '0;
		endcase
	end

	always_comb begin
		case (alu_op)
			op_add:  overflow = ovf_add;
			op_sub:  overflow = ovf_sub;
			default: overflow = 1'b0;  // only arithmetic reports it
		endcase
	end

	assign is_not_equal = |sum_sub;
	assign is_less_than = sum_sub[31] ^ ovf_sub;  // signed compare

endmodule

`default_nettype wire

// ==== src/alu_status_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module alu_status_regs #(
	parameter int COUNT_WIDTH = 8
) (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     out_valid,
	input  wire                     overflow,
	input  wire                     clear_status,
	output logic                    sticky_overflow,
	output logic [COUNT_WIDTH-1:0]  overflow_count
);

	logic count_full;

	assign count_full = &overflow_count;

	always_ff @(posedge clock) begin
		if (reset || clear_status) begin  // clear wins over a new overflow
			sticky_overflow <= 1'b0;
			overflow_count  <= '0;
		end else if (out_valid && overflow) begin
			sticky_overflow <= 1'b1;
			if (!count_full)
				overflow_count <= overflow_count + 1'b1;
		end
	end

	// saturating, so all ones only drops to zero through a clear
	a_no_wrap: assert property (@(posedge clock) disable iff (reset)
		($past(overflow_count) == '1 && overflow_count == '0)
		|-> $past(clear_status || reset));

	a_sticky_holds: assert property (@(posedge clock) disable iff (reset)
		$past(sticky_overflow) && !$past(clear_status || reset) |-> sticky_overflow);

endmodule

`default_nettype wire

// ==== src/exec_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ns

module exec_pipeline (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    in_valid,
	input  wire exec_pkg::word_t   data_a,
	input  wire exec_pkg::word_t   data_b,
	input  wire exec_pkg::alu_op_t alu_op,
	input  wire exec_pkg::shamt_t  shamt,
	output logic                   out_valid,
	output exec_pkg::word_t        result,
	output logic                   is_not_equal,
	output logic                   is_less_than,
	output logic                   overflow
);
	import exec_pkg::*;

	logic    op_valid;  // operand stage holds a live op
	word_t   a_reg;
	word_t   b_reg;
	alu_op_t op_reg;
	shamt_t  shamt_reg;

	word_t   alu_result;
	logic    alu_ne;
	logic    alu_lt;
	logic    alu_ovf;

	always_ff @(posedge clock) begin
		if (reset) begin
			op_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			op_valid  <= in_valid;
			out_valid <= op_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			a_reg     <= data_a;
			b_reg     <= data_b;
			op_reg    <= alu_op;
			shamt_reg <= shamt;
		end
		if (op_valid) begin  // outputs hold between pulses
			result       <= alu_result;
			is_not_equal <= alu_ne;
			is_less_than <= alu_lt;
			overflow     <= alu_ovf;
		end
	end

	alu u_alu (
		.data_a       (a_reg),
		.data_b       (b_reg),
		.alu_op       (op_reg),
		.shamt        (shamt_reg),
		.result       (alu_result),
		.is_not_equal (alu_ne),
		.is_less_than (alu_lt),
		.overflow     (alu_ovf)
	);

	// every accepted op comes out two edges later, nothing else does
	a_in_to_out: assert property (@(posedge clock) disable iff (reset)
		$past(in_valid && !reset, 2) && !$past(reset) |-> out_valid);
	a_out_from_in: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> $past(in_valid, 2));

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	typedef logic [31:0] word_t;   // operands and results
	typedef logic [4:0]  shamt_t;  // barrel shift distance
	typedef logic [4:0]  alu_op_t;

	// alu opcodes
	// codes not listed here give a zero result
	localparam alu_op_t op_add = 5'd0;
	localparam alu_op_t op_sub = 5'd1;
	localparam alu_op_t op_and = 5'd2;
	localparam alu_op_t op_or  = 5'd3;
	localparam alu_op_t op_sll = 5'd4;
	localparam alu_op_t op_sra = 5'd5;

endpackage

`default_nettype wire

// ==== src/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module execute_stage #(
	parameter int COUNT_WIDTH = 8
) (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    in_valid,
	input  wire exec_pkg::word_t   data_a,
	input  wire exec_pkg::word_t   data_b,
	input  wire exec_pkg::alu_op_t alu_op,
	input  wire exec_pkg::shamt_t  shamt,
	input  wire                    clear_status,
	output logic                   out_valid,
	output exec_pkg::word_t        result,
	output logic                   is_not_equal,
	output logic                   is_less_than,
	output logic                   overflow,
	output logic                   sticky_overflow,
	output logic [COUNT_WIDTH-1:0] overflow_count
);

	exec_pipeline u_pipeline (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (in_valid),
		.data_a       (data_a),
		.data_b       (data_b),
		.alu_op       (alu_op),
		.shamt        (shamt),
		.out_valid    (out_valid),
		.result       (result),
		.is_not_equal (is_not_equal),
		.is_less_than (is_less_than),
		.overflow     (overflow)
	);

	// watches the result stage only
	alu_status_regs #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_status (
		.clock           (clock),
		.reset           (reset),
		.out_valid       (out_valid),
		.overflow        (overflow),
		.clear_status    (clear_status),
		.sticky_overflow (sticky_overflow),
		.overflow_count  (overflow_count)
	);

endmodule

`default_nettype wire

// ==== src/shift_left_logical.sv ====
`default_nettype none
`timescale 1ns/1ns

module shift_left_logical (
	input  wire exec_pkg::word_t  in,
	input  wire exec_pkg::shamt_t shamt,
	output exec_pkg::word_t       out
);
	import exec_pkg::*;

	wire word_t stage [0:5];
	word_t      low_mask;  // ones over the bits that must be vacated

	assign stage[0] = in;

	genvar s, i;
	generate
		for (s = 0; s < 5; s++) begin : g_stage
			localparam int AMT = 1 << s;

			for (i = 0; i < 32; i++) begin : g_bit
				if (i >= AMT) begin : g_move
					assign stage[s+1][i] = shamt[s] ? stage[s][i-AMT] : stage[s][i];
				end else begin : g_fill
					assign stage[s+1][i] = shamt[s] ? 1'b0 : stage[s][i];  // zero fill
				end
			end
		end
	endgenerate

	assign out = stage[5];

	assign low_mask = (word_t'(1) << shamt) - word_t'(1);

	a_zero_fill: assert #0 ((out & low_mask) == '0)
		else $error("sll left ones in vacated bits, in=%h shamt=%0d out=%h", in, shamt, out);

endmodule

`default_nettype wire

// ==== src/shift_right_arithmetic.sv ====
`default_nettype none
`timescale 1ns/1ns

module shift_right_arithmetic (
	input  wire exec_pkg::word_t  in,
	input  wire exec_pkg::shamt_t shamt,
	output exec_pkg::word_t       out
);
	import exec_pkg::*;

	// stage[k] holds the input after the low k shamt bits are applied
	wire word_t stage [0:5];

	assign stage[0] = in;

	genvar s, i;
	generate
		for (s = 0; s < 5; s++) begin : g_stage
			localparam int AMT = 1 << s;  // 1, 2, 4, 8, 16

			for (i = 0; i < 32; i++) begin : g_bit
				if (i < 32 - AMT) begin : g_move
					assign stage[s+1][i] = shamt[s] ? stage[s][i+AMT] : stage[s][i];
				end else begin : g_fill
					// top AMT bits take the original sign
					assign stage[s+1][i] = shamt[s] ? in[31] : stage[s][i];
				end
			end
		end
	endgenerate

	assign out = stage[5];

	// sign survives any shift distance
	a_sign_kept: assert #0 (shamt == '0 || out[31] == in[31])
		else $error("sra lost the sign bit, in=%h shamt=%0d out=%h", in, shamt, out);

endmodule

`default_nettype wire

// ==== verif/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected alu result for one operation
function automatic word_t expected_result(
	input word_t   a,
	input word_t   b,
	input alu_op_t op,
	input shamt_t  sh
);
	logic signed [31:0] a_signed;
	a_signed = a;
	case (op)
		op_add:  return a + b;
		op_sub:  return a - b;
		op_and:  return a & b;
		op_or:   return a | b;
		op_sll:  return a << sh;
		op_sra:  return a_signed >>> sh;  // sign fill
		default: return '0;
	endcase
endfunction

// signed overflow of add and sub only
function automatic logic arith_overflow(input word_t a, input word_t b, input alu_op_t op);
	word_t sum;
	word_t diff;
	sum  = a + b;
	diff = a - b;
	case (op)
		op_add:  return (a[31] == b[31]) && (sum[31] != a[31]);
		op_sub:  return (a[31] != b[31]) && (diff[31] != a[31]);
		default: return 1'b0;
	endcase
endfunction

function automatic logic operands_differ(input word_t a, input word_t b);
	return a != b;
endfunction

function automatic logic signed_less_than(input word_t a, input word_t b);
	return $signed(a) < $signed(b);
endfunction

`endif

// ==== verif/execute_stage_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module execute_stage_tb;
	import exec_pkg::*;

	`include "alu_model.svh"

	localparam int COUNT_WIDTH = 8;
	localparam int CLK_PERIOD  = 20;
	localparam int N_DIRECTED  = 12;
	localparam int N_SWEEP     = 96;
	localparam int N_RANDOM    = 200;
	localparam int N_SATURATE  = 300;
	localparam int N_AFTER     = 8;
	localparam int N_OPS       = N_DIRECTED + N_SWEEP + N_RANDOM + N_SATURATE + N_AFTER;

	logic                   clock = 1'b0;
	logic                   reset;
	logic                   in_valid;
	word_t                  data_a;
	word_t                  data_b;
	alu_op_t                alu_op;
	shamt_t                 shamt;
	logic                   clear_status;
	logic                   out_valid;
	word_t                  result;
	logic                   is_not_equal;
	logic                   is_less_than;
	logic                   overflow;
	logic                   sticky_overflow;
	logic [COUNT_WIDTH-1:0] overflow_count;

	logic [34:0]            exp_q [$];  // {result, ne, lt, ovf}
	word_t                  exp_result = '0;
	logic                   exp_ne = 1'b0;
	logic                   exp_lt = 1'b0;
	logic                   exp_overflow = 1'b0;
	logic                   exp_valid = 1'b0;  // out_valid seen this cycle
	logic                   model_sticky = 1'b0;
	logic [COUNT_WIDTH-1:0] model_count = '0;
	integer                 seed = 32'h0bf8_fe97;
	word_t                  rnd_a;
	word_t                  rnd_b;
	logic [31:0]            rnd_word;

	execute_stage #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_dut (
		.clock           (clock),
		.reset           (reset),
		.in_valid        (in_valid),
		.data_a          (data_a),
		.data_b          (data_b),
		.alu_op          (alu_op),
		.shamt           (shamt),
		.clear_status    (clear_status),
		.out_valid       (out_valid),
		.result          (result),
		.is_not_equal    (is_not_equal),
		.is_less_than    (is_less_than),
		.overflow        (overflow),
		.sticky_overflow (sticky_overflow),
		.overflow_count  (overflow_count)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// drives one op from a falling edge to the next
	task automatic send_op(input word_t a, input word_t b, input alu_op_t op, input shamt_t sh);
		data_a   = a;
		data_b   = b;
		alu_op   = op;
		shamt    = sh;
		in_valid = 1'b1;
		exp_q.push_back({expected_result(a, b, op, sh), operands_differ(a, b),
			signed_less_than(a, b), arith_overflow(a, b, op)});
		@(negedge clock);
	endtask

	task automatic idle(input int cycles);
		in_valid = 1'b0;
		repeat (cycles) @(negedge clock);
	endtask

	// popped on the falling edge so values are stable at the rising one
	always @(negedge clock) begin
		exp_valid = out_valid;
		if (out_valid) begin
			if (exp_q.size() == 0)
				stop_run("out_valid arrived with no operation waiting for it");
			else
				{exp_result, exp_ne, exp_lt, exp_overflow} = exp_q.pop_front();
		end
	end

	always @(posedge clock) begin
		if (reset || clear_status) begin
			model_sticky <= 1'b0;
			model_count  <= '0;
		end else if (exp_valid && exp_overflow) begin
			model_sticky <= 1'b1;
			if (model_count != '1)
				model_count <= model_count + 1'b1;  // saturate
		end
	end

	a_result: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> result == exp_result)
		else stop_run($sformatf("[FAIL] %0t result %h, expected %h",
			$time, $sampled(result), $sampled(exp_result)));

	a_not_equal: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> is_not_equal == exp_ne)
		else stop_run($sformatf("[FAIL] %0t is_not_equal %0b, expected %0b",
			$time, $sampled(is_not_equal), $sampled(exp_ne)));

	a_less_than: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> is_less_than == exp_lt)
		else stop_run($sformatf("[FAIL] %0t is_less_than %0b, expected %0b",
			$time, $sampled(is_less_than), $sampled(exp_lt)));

	a_overflow: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> overflow == exp_overflow)
		else stop_run($sformatf("[FAIL] %0t overflow %0b, expected %0b",
			$time, $sampled(overflow), $sampled(exp_overflow)));

	a_latency: assert property (@(posedge clock) disable iff (reset)
		in_valid |-> ##2 out_valid)
		else stop_run($sformatf("[FAIL] %0t out_valid missing two edges after in_valid", $time));

	a_no_extra: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> $past(in_valid, 2))
		else stop_run($sformatf("[FAIL] %0t out_valid without a matching input", $time));

	a_status: assert property (@(posedge clock) disable iff (reset)
		sticky_overflow == model_sticky && overflow_count == model_count)
		else stop_run($sformatf("[FAIL] %0t sticky %0b count %0d, expected sticky %0b count %0d",
			$time, $sampled(sticky_overflow), $sampled(overflow_count),
			$sampled(model_sticky), $sampled(model_count)));

	initial begin
		#((N_OPS + 50) * CLK_PERIOD);
		stop_run("timeout: out_valid never arrived for every operation sent");
	end

	initial begin
		reset        = 1'b1;
		in_valid     = 1'b0;
		data_a       = '0;
		data_b       = '0;
		alu_op       = op_add;
		shamt        = '0;
		clear_status = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		idle(3);  // out_valid must stay low here

		// overflow edges and plain arithmetic
		send_op(32'h7fff_ffff, 32'h0000_0001, op_add, 5'd0);
		send_op(32'h8000_0000, 32'h0000_0001, op_sub, 5'd0);
		send_op(32'h8000_0000, 32'h8000_0000, op_add, 5'd0);
		send_op(32'h7fff_ffff, 32'hffff_ffff, op_sub, 5'd0);
		send_op(32'h1234_5678, 32'h0edc_ba98, op_add, 5'd0);
		send_op(32'h0000_0005, 32'h0000_0007, op_sub, 5'd0);
		// logic, undefined codes, compare extremes
		send_op(32'hf0f0_f0f0, 32'h0ff0_0ff0, op_and, 5'd3);
		send_op(32'hf0f0_f0f0, 32'h0ff0_0ff0, op_or, 5'd7);
		send_op(32'ha5a5_a5a5, 32'ha5a5_a5a5, 5'd6, 5'd1);
		send_op(32'h8000_0000, 32'h7fff_ffff, 5'd31, 5'd0);
		send_op(32'h7fff_ffff, 32'h8000_0000, op_and, 5'd0);
		send_op(32'h0000_0000, 32'h0000_0000, op_sub, 5'd0);

		for (int sh = 0; sh < 32; sh++) begin
			send_op(32'h8765_4321, 32'h0000_0000, op_sra, shamt_t'(sh));
			send_op(32'h3c5a_96e1, 32'h0000_0000, op_sra, shamt_t'(sh));
			send_op(32'hffff_ffff, 32'h0000_0000, op_sll, shamt_t'(sh));
		end

		// back to back random ops over every 3-bit opcode
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd_a    = $random(seed);
			rnd_b    = $random(seed);
			rnd_word = $random(seed);
			send_op(rnd_a, rnd_b, alu_op_t'(rnd_word[2:0]), rnd_word[12:8]);
		end

		// two positive operands above 2^30 always overflow when added
		for (int n = 0; n < N_SATURATE; n++) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			rnd_a[31:30] = 2'b01;
			rnd_b[31:30] = 2'b01;
			send_op(rnd_a, rnd_b, op_add, 5'd0);
		end

		idle(4);
		clear_status = 1'b1;
		@(negedge clock);
		clear_status = 1'b0;
		idle(2);

		// clear lands on the edge of an overflowing result
		send_op(32'h7fff_fff0, 32'h0000_0100, op_add, 5'd0);
		send_op(32'h8000_0010, 32'h0000_0100, op_sub, 5'd0);
		send_op(32'h4000_0000, 32'h4000_0000, op_add, 5'd0);
		clear_status = 1'b1;
		send_op(32'h6000_0000, 32'h5000_0000, op_add, 5'd0);
		clear_status = 1'b0;
		send_op(32'h0000_0010, 32'h0000_0020, op_add, 5'd0);
		send_op(32'hffff_fff0, 32'h0000_0001, op_sub, 5'd0);
		send_op(32'h1111_1111, 32'h2222_2222, op_or, 5'd0);
		send_op(32'h8000_0000, 32'h0000_0001, op_sub, 5'd0);

		idle(5);
		if (exp_q.size() != 0) begin
			stop_run($sformatf("%0d operations never came out of the stage", exp_q.size()));
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
